// ==== flist.f ====
+incdir+source
source/wb_bridge_pkg.sv
source/two_entry_fifo.sv
source/fwd_stream_pump.sv
source/wb_cmd_drive.sv
source/rev_stream_pump.sv
source/wb_master_bridge.sv
tb/wb_master_bridge_assert.sv
tb/wb_master_bridge_tb.sv

// ==== tb/wb_master_bridge_tb.sv ====
/* directed testbench for the bridge; the memory model covers word addresses
   below 1024 and never raises err or rty */
`default_nettype none

`include "wb_bridge_params.svh"

module wb_master_bridge_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import wb_bridge_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int MEM_WORDS = 1024;
  localparam int LANES     = `WB_SEL_WIDTH;

  logic        clk_i;
  logic        rst_n_i;
  fwd_msg_s    fwd_msg_i;
  logic        fwd_v_i;
  logic        fwd_ready_and_o;
  mem_header_s rev_header_o;
  wb_data_t    rev_data_o;
  logic        rev_v_o;
  logic        rev_ready_and_i;
  wb_req_s     wb_req_o;
  logic        cyc_o;
  logic        stb_o;
  wb_data_t    dat_i;
  logic        ack_i;

  wb_data_t    mem [MEM_WORDS];
  integer      seed;
  int          ack_wait;
  logic        ack_pending;

  wb_req_s     req_log[$];
  mem_header_s hdr_q[$];
  wb_data_t    data_q[$];
  wb_req_s     exp_req_q[$];
  mem_header_s exp_hdr_q[$];
  wb_data_t    exp_data_q[$];

  int hdr_errs;
  int data_errs;
  int req_errs;
  int other_errs;

  wb_master_bridge DUT (.*);

  bind wb_master_bridge wb_master_bridge_assert checks (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // memory slave that acks each strobe after 0 to 3 cycles
  always @(negedge clk_i) begin
    int unsigned a;
    ack_i = 1'b0;
    if (!rst_n_i) begin
      ack_pending = 1'b0;
    end else if (stb_o && cyc_o) begin
      if (!ack_pending) begin
        ack_pending = 1'b1;
        ack_wait    = $unsigned($random(seed)) % 4;
      end
      if (ack_wait == 0) begin
        a           = wb_req_o.adr % MEM_WORDS;
        ack_pending = 1'b0;
        ack_i       = 1'b1;
        req_log.push_back(wb_req_o);
        if (wb_req_o.we) begin
          for (int i = 0; i < LANES; i++) begin
            if (wb_req_o.sel[i]) begin
              mem[a][8*i +: 8] = wb_req_o.dat[8*i +: 8];
            end
          end
        end
        dat_i = mem[a];
      end else begin
        ack_wait--;
      end
    end
  end

  // response monitor
  always @(posedge clk_i) begin
    if (rst_n_i && rev_v_o && rev_ready_and_i) begin
      hdr_q.push_back(rev_header_o);
      data_q.push_back(rev_data_o);
    end
  end

  function automatic wb_data_t fill_word(int unsigned adr);
    return {32'(adr) ^ 32'hc0de_0000, 32'(adr) * 32'h0101_0101 ^ 32'h00ff_f00f};
  endfunction

  function automatic wb_sel_t sel_rule(msg_size_e size, int unsigned off);
    wb_sel_t m;
    case (size)
      e_size_1: m = 8'h01;
      e_size_2: m = 8'h03;
      e_size_4: m = 8'h0f;
      default:  m = 8'hff;
    endcase
    return m << off;
  endfunction

  function automatic wb_data_t replicate(msg_size_e size, wb_data_t word, int unsigned off);
    wb_data_t w;
    w = word >> (8 * off);
    case (size)
      e_size_1: return {8{w[7:0]}};
      e_size_2: return {4{w[15:0]}};
      e_size_4: return {2{w[31:0]}};
      default:  return word;
    endcase
  endfunction

  function automatic mem_header_s make_hdr(msg_type_e t, msg_size_e s, paddr_t addr,
                                           logic [7:0] tag);
    mem_header_s h;
    h.msg_type = t;
    h.size     = s;
    h.addr     = addr;
    h.tag      = tag;
    return h;
  endfunction

  function automatic wb_req_s make_req(wb_adr_t adr, wb_data_t dat, wb_sel_t sel, logic we,
                                       wb_cti_e cti, wb_bte_e bte);
    wb_req_s r;
    r.adr = adr;
    r.dat = dat;
    r.sel = sel;
    r.we  = we;
    r.cti = cti;
    r.bte = bte;
    return r;
  endfunction

  task automatic compare_header(string name, mem_header_s exp, mem_header_s act);
    if (act !== exp) begin
      hdr_errs++;
      $display("Mismatch in %s header: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_data(string name, wb_data_t exp, wb_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("Mismatch in %s data: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_req(string name, wb_req_s exp, wb_req_s act);
    if (act !== exp) begin
      req_errs++;
      $display("Mismatch in %s bus request: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic send_cmd(mem_header_s hdr, wb_data_t data);
    @(negedge clk_i);
    fwd_msg_i.header = hdr;
    fwd_msg_i.data   = data;
    fwd_v_i          = 1'b1;
    @(posedge clk_i);
    while (!fwd_ready_and_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    fwd_v_i = 1'b0;
  endtask

  task automatic expect_resp(mem_header_s hdr, wb_data_t data);
    exp_hdr_q.push_back(hdr);
    exp_data_q.push_back(data);
  endtask

  task automatic check_results(string name);
    int cycles;
    cycles = 0;
    while ((hdr_q.size() < exp_hdr_q.size() || req_log.size() < exp_req_q.size())
           && cycles < 150) begin
      @(posedge clk_i);
      cycles++;
    end
    if (hdr_q.size() < exp_hdr_q.size() || req_log.size() < exp_req_q.size()) begin
      other_errs++;
      $display("%s: timed out waiting for responses or bus beats", name);
    end
    // late extra beats still show up as leftovers
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    while (exp_req_q.size() > 0 && req_log.size() > 0) begin
      compare_req(name, exp_req_q.pop_front(), req_log.pop_front());
    end
    while (exp_hdr_q.size() > 0 && hdr_q.size() > 0) begin
      compare_header(name, exp_hdr_q.pop_front(), hdr_q.pop_front());
      compare_data(name, exp_data_q.pop_front(), data_q.pop_front());
    end
    if (req_log.size() + hdr_q.size() + exp_req_q.size() + exp_hdr_q.size() != 0) begin
      other_errs++;
      $display("%s: %0d bus beats and %0d responses left unmatched", name,
               req_log.size() + exp_req_q.size(), hdr_q.size() + exp_hdr_q.size());
    end
    req_log.delete();
    hdr_q.delete();
    data_q.delete();
    exp_req_q.delete();
    exp_hdr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic reset_outputs_low();
    if (cyc_o !== 1'b0 || stb_o !== 1'b0 || rev_v_o !== 1'b0) begin
      other_errs++;
      $display("reset_state: cyc_o, stb_o or rev_v_o not low right after reset release");
    end
    if (fwd_ready_and_o !== 1'b0) begin
      other_errs++;
      $display("reset_state: fwd_ready_and_o high before the first cycle out of reset");
    end
  endtask

  task automatic single_word_write_read();
    mem_header_s wr_h;
    mem_header_s rd_h;
    wb_data_t    d;
    d    = 64'h0123_4567_89ab_cdef;
    wr_h = make_hdr(e_mem_uc_wr, e_size_8, 32'h40, 8'h11);
    rd_h = make_hdr(e_mem_uc_rd, e_size_8, 32'h40, 8'h12);
    send_cmd(wr_h, d);
    send_cmd(rd_h, '0);
    // byte address 0x40 is bus word 8
    exp_req_q.push_back(make_req(8, d, 8'hff, 1'b1, e_wb_end_of_burst, e_wb_linear_burst));
    exp_req_q.push_back(make_req(8, '0, 8'hff, 1'b0, e_wb_end_of_burst, e_wb_linear_burst));
    expect_resp(wr_h, '0);
    expect_resp(rd_h, d);
    check_results("single_word");
  endtask

  task automatic narrow_accesses();
    msg_size_e   size;
    mem_header_s wr_h;
    mem_header_s rd_h;
    mem_header_s full_h;
    wb_data_t    data;
    wb_data_t    exp_word;
    wb_sel_t     sel;
    int unsigned word;
    int unsigned nbytes;
    logic [7:0]  tag;
    tag = 8'h20;
    for (int s = 0; s < 3; s++) begin
      size     = msg_size_e'(s);
      nbytes   = 1 << s;
      word     = 32'h20 + s;
      exp_word = fill_word(word);
      for (int off = 0; off < LANES; off += nbytes) begin
        data = replicate(size, {$random(seed), $random(seed)}, 0);
        sel  = sel_rule(size, off);
        for (int i = 0; i < LANES; i++) begin
          if (sel[i]) begin
            exp_word[8*i +: 8] = data[8*i +: 8];
          end
        end
        wr_h   = make_hdr(e_mem_uc_wr, size, word * 8 + off, tag);
        rd_h   = make_hdr(e_mem_uc_rd, size, word * 8 + off, tag + 8'd1);
        full_h = make_hdr(e_mem_uc_rd, e_size_8, word * 8, tag + 8'd2);
        tag    = tag + 8'd3;
        send_cmd(wr_h, data);
        send_cmd(rd_h, '0);
        send_cmd(full_h, '0);
        exp_req_q.push_back(make_req(word, data, sel, 1'b1, e_wb_end_of_burst,
                                     e_wb_linear_burst));
        exp_req_q.push_back(make_req(word, '0, sel, 1'b0, e_wb_end_of_burst,
                                     e_wb_linear_burst));
        exp_req_q.push_back(make_req(word, '0, 8'hff, 1'b0, e_wb_end_of_burst,
                                     e_wb_linear_burst));
        expect_resp(wr_h, '0);
        expect_resp(rd_h, replicate(size, exp_word, off));
        // full word shows the bytes outside sel kept their values
        expect_resp(full_h, exp_word);
      end
      check_results($sformatf("narrow_%0d_byte", nbytes));
    end
  endtask

  task automatic wrapped_read(string name, msg_size_e size, int unsigned base,
                              int unsigned start);
    mem_header_s h;
    int unsigned n;
    int unsigned w;
    n = (size == e_size_32) ? 4 : 8;
    h = make_hdr(e_mem_uc_rd, size, base + start * 8, 8'h30 + 8'(n));
    send_cmd(h, '0);
    for (int unsigned k = 0; k < n; k++) begin
      w = base / 8 + (start + k) % n;
      exp_req_q.push_back(make_req(w, '0, 8'hff, 1'b0,
                                   (k == n - 1) ? e_wb_end_of_burst : e_wb_inc_addr_burst,
                                   (n == 4) ? e_wb_4_beat_wrap_burst : e_wb_8_beat_wrap_burst));
      expect_resp(h, fill_word(w));
    end
    check_results(name);
  endtask

  task automatic multi_beat_write();
    mem_header_s h;
    wb_data_t    d [8];
    h = make_hdr(e_mem_uc_wr, e_size_64, 32'h400, 8'h40);
    for (int k = 0; k < 8; k++) begin
      d[k] = {$random(seed), $random(seed)};
      send_cmd(h, d[k]);
      exp_req_q.push_back(make_req(32'h80 + k, d[k], 8'hff, 1'b1,
                                   (k == 7) ? e_wb_end_of_burst : e_wb_inc_addr_burst,
                                   e_wb_8_beat_wrap_burst));
    end
    expect_resp(h, '0);
    check_results("multi_write");
    for (int k = 0; k < 8; k++) begin
      compare_data("multi_write", d[k], mem[32'h80 + k]);
    end
  endtask

  task automatic stalled_responses();
    mem_header_s h1;
    mem_header_s h2;
    int unsigned w;
    h1 = make_hdr(e_mem_uc_rd, e_size_32, 32'h508, 8'h50);
    h2 = make_hdr(e_mem_uc_rd, e_size_8, 32'h540, 8'h51);
    @(negedge clk_i);
    rev_ready_and_i = 1'b0;
    send_cmd(h1, '0);
    send_cmd(h2, '0);
    for (int unsigned k = 0; k < 4; k++) begin
      w = 32'ha0 + (1 + k) % 4;
      exp_req_q.push_back(make_req(w, '0, 8'hff, 1'b0,
                                   (k == 3) ? e_wb_end_of_burst : e_wb_inc_addr_burst,
                                   e_wb_4_beat_wrap_burst));
      expect_resp(h1, fill_word(w));
    end
    exp_req_q.push_back(make_req(32'ha8, '0, 8'hff, 1'b0, e_wb_end_of_burst,
                                 e_wb_linear_burst));
    expect_resp(h2, fill_word(32'ha8));
    repeat (20) @(negedge clk_i);
    if (cyc_o !== 1'b0) begin
      other_errs++;
      $display("back_pressure: cyc_o still high while the return FIFO is full");
    end
    if (fwd_ready_and_o !== 1'b0) begin
      other_errs++;
      $display("back_pressure: fwd_ready_and_o still high while the command FIFO is full");
    end
    if (req_log.size() != 2) begin
      other_errs++;
      $display("back_pressure: %0d bus beats acked during the stall, expected 2",
               req_log.size());
    end
    rev_ready_and_i = 1'b1;
    check_results("back_pressure");
  endtask

  initial begin
    int total;
    seed            = 32'hc1238d27;
    rst_n_i         = 1'b0;
    fwd_msg_i       = '0;
    fwd_v_i         = 1'b0;
    rev_ready_and_i = 1'b1;
    dat_i           = '0;
    ack_i           = 1'b0;
    ack_pending     = 1'b0;
    ack_wait        = 0;
    hdr_errs        = 0;
    data_errs       = 0;
    req_errs        = 0;
    other_errs      = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    reset_outputs_low();
    single_word_write_read();
    narrow_accesses();
    wrapped_read("wrap_32", e_size_32, 32'h200, 2);
    wrapped_read("wrap_64", e_size_64, 32'h300, 5);
    multi_beat_write();
    stalled_responses();
    total = hdr_errs + data_errs + req_errs + other_errs + DUT.checks.assert_errs;
    $display("errors: header %0d, data %0d, bus request %0d, assertion %0d, other %0d",
             hdr_errs, data_errs, req_errs, DUT.checks.assert_errs, other_errs);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // 200 cycles for each test
  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the tests did not complete",
             NUM_TESTS * 200);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/wb_master_bridge_assert.sv ====
/* protocol checks bound into the bridge; wide commands may start at any bus word
   of their block, so alignment is only checked up to one bus word */
`default_nettype none

module wb_master_bridge_assert (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  wb_bridge_pkg::fwd_msg_s    fwd_msg_i,
  input  logic                       fwd_v_i,
  input  wb_bridge_pkg::wb_req_s     wb_req_o,
  input  logic                       cyc_o,
  input  logic                       stb_o,
  input  logic                       ack_i,
  input  wb_bridge_pkg::mem_header_s rev_header_o,
  input  wb_bridge_pkg::wb_data_t    rev_data_o,
  input  logic                       rev_v_o,
  input  logic                       rev_ready_and_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import wb_bridge_pkg::*;

  int         assert_errs = 0;
  logic [2:0] size_log;
  logic [2:0] low_mask;

  // byte offset bits that must be zero for the command size
  assign size_log = (fwd_msg_i.header.size > e_size_8) ? 3'd3 : fwd_msg_i.header.size;
  assign low_mask = 3'((4'd1 << size_log) - 4'd1);

  aligned_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fwd_v_i |-> ((fwd_msg_i.header.addr[2:0] & low_mask) == 3'd0))
    else begin
      assert_errs++;
      $error("command address is not aligned to its size");
    end

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stb_o |-> cyc_o)
    else begin
      assert_errs++;
      $error("stb_o high outside a cycle");
    end

  // the master may not retract or change a request before its ack
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cyc_o && !ack_i) |=> (cyc_o && $stable(wb_req_o)))
    else begin
      assert_errs++;
      $error("Wishbone request changed or dropped before ack");
    end

  rev_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rev_v_o && !rev_ready_and_i) |=> (rev_v_o && $stable(rev_header_o)
      && $stable(rev_data_o)))
    else begin
      assert_errs++;
      $error("response changed or dropped before ready");
    end

endmodule

`default_nettype wire

// ==== source/wb_master_bridge.sv ====
/* uncached memory command to Wishbone B4 master bridge, 64-bit bus only
   up to two commands buffered at the input and two acks at the return */
`default_nettype none

module wb_master_bridge (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  wb_bridge_pkg::fwd_msg_s    fwd_msg_i,
  input  logic                       fwd_v_i,
  output logic                       fwd_ready_and_o,

  output wb_bridge_pkg::mem_header_s rev_header_o,
  output wb_bridge_pkg::wb_data_t    rev_data_o,
  output logic                       rev_v_o,
  input  logic                       rev_ready_and_i,

  output wb_bridge_pkg::wb_req_s     wb_req_o,
  output logic                       cyc_o,
  output logic                       stb_o,
  input  wb_bridge_pkg::wb_data_t    dat_i,
  input  logic                       ack_i
);

  import wb_bridge_pkg::*;

  fsm_beat_s  beat;
  logic       beat_v, beat_yumi;
  rev_entry_s ret_entry;
  logic       ret_v, ret_ready;
  rev_entry_s rev_entry;
  logic       rev_entry_v, rev_entry_yumi;

  fwd_stream_pump pump_in (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fwd_msg_i      (fwd_msg_i),
    .fwd_v_i        (fwd_v_i),
    .fwd_ready_and_o(fwd_ready_and_o),
    .beat_o         (beat),
    .beat_v_o       (beat_v),
    .beat_yumi_i    (beat_yumi)
  );

  wb_cmd_drive drive (
    .beat_i     (beat),
    .beat_v_i   (beat_v),
    .beat_yumi_o(beat_yumi),
    .ret_ready_i(ret_ready),
    .ret_v_o    (ret_v),
    .ret_entry_o(ret_entry),
    .wb_req_o   (wb_req_o),
    .cyc_o      (cyc_o),
    .stb_o      (stb_o),
    .dat_i      (dat_i),
    .ack_i      (ack_i)
  );

  // return FIFO absorbs acks while the response side is stalled
  two_entry_fifo #(
    .payload_t(rev_entry_s)
  ) return_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (ret_entry),
    .v_i    (ret_v),
    .ready_o(ret_ready),
    .data_o (rev_entry),
    .v_o    (rev_entry_v),
    .yumi_i (rev_entry_yumi)
  );

  rev_stream_pump pump_out (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .entry_i        (rev_entry),
    .entry_v_i      (rev_entry_v),
    .entry_yumi_o   (rev_entry_yumi),
    .rev_header_o   (rev_header_o),
    .rev_data_o     (rev_data_o),
    .rev_v_o        (rev_v_o),
    .rev_ready_and_i(rev_ready_and_i)
  );

endmodule

`default_nettype wire

// ==== source/rev_stream_pump.sv ====
/* turns acked beats into responses; one per read beat, one per write message
   narrow read data is replicated over the whole bus word */
`default_nettype none

`include "wb_bridge_params.svh"

module rev_stream_pump (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  wb_bridge_pkg::rev_entry_s entry_i,
  input  logic                      entry_v_i,
  output logic                      entry_yumi_o,

  output wb_bridge_pkg::mem_header_s rev_header_o,
  output wb_bridge_pkg::wb_data_t   rev_data_o,
  output logic                      rev_v_o,
  input  logic                      rev_ready_and_i
);

  import wb_bridge_pkg::*;

  localparam int OFF_W = `WB_OFFSET_WIDTH;
  localparam int CNT_W = `WB_BEAT_CNT_WIDTH;
  localparam int DW    = `WB_DATA_WIDTH;

  logic             is_wr;
  logic             drop;
  logic [OFF_W-1:0] byte_off;
  beat_cnt_t        cnt_q;
  beat_cnt_t        mask;
  beat_cnt_t        beat_word;
  beat_cnt_t        base_word;
  wb_data_t         shifted;

  assign is_wr = (entry_i.header.msg_type == e_mem_uc_wr);

  // only the final write ack produces a response
  assign drop = is_wr && !entry_i.last;

  assign rev_v_o      = entry_v_i && !drop;
  assign entry_yumi_o = entry_v_i && (drop || rev_ready_and_i);

  // undo the wrap so the header matches the command again
  assign mask      = beat_mask(entry_i.header.size);
  assign beat_word = entry_i.header.addr[OFF_W +: CNT_W];
  assign base_word = (beat_word & ~mask) | ((beat_word - cnt_q) & mask);

  assign byte_off = entry_i.header.addr[OFF_W-1:0];
  assign shifted  = entry_i.data >> {byte_off, 3'b000};

  always_comb begin
    rev_header_o = entry_i.header;
    rev_header_o.addr[OFF_W +: CNT_W] = base_word;
    if (is_wr) begin
      rev_data_o = '0;
    end else begin
      case (entry_i.header.size)
        e_size_1: rev_data_o = {(DW / 8){shifted[7:0]}};
        e_size_2: rev_data_o = {(DW / 16){shifted[15:0]}};
        e_size_4: rev_data_o = {(DW / 32){shifted[31:0]}};
        default:  rev_data_o = entry_i.data;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (entry_yumi_o) begin
      cnt_q <= entry_i.last ? '0 : cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/wb_cmd_drive.sv ====
/* purely combinational Wishbone request stage, no err/rty/stall support
   a beat is offered only when the return FIFO can take its ack */
`default_nettype none

module wb_cmd_drive (
  input  wb_bridge_pkg::fsm_beat_s  beat_i,
  input  logic                      beat_v_i,
  output logic                      beat_yumi_o,

  input  logic                      ret_ready_i,
  output logic                      ret_v_o,
  output wb_bridge_pkg::rev_entry_s ret_entry_o,

  output wb_bridge_pkg::wb_req_s    wb_req_o,
  output logic                      cyc_o,
  output logic                      stb_o,
  input  wb_bridge_pkg::wb_data_t   dat_i,
  input  logic                      ack_i
);

  import wb_bridge_pkg::*;

  localparam int ADDR_W = $bits(paddr_t);
  localparam int OFF_W  = ADDR_W - $bits(wb_adr_t);

  wb_sel_t   size_mask;
  beat_cnt_t burst_mask;

  assign cyc_o = beat_v_i && ret_ready_i;
  assign stb_o = cyc_o;

  // an acked beat leaves the pump and enters the return FIFO together
  assign beat_yumi_o = stb_o && ack_i;
  assign ret_v_o     = beat_yumi_o;

  // beat address rides back in the header so the response side knows the word
  always_comb begin
    ret_entry_o.header      = beat_i.header;
    ret_entry_o.header.addr = beat_i.addr;
    ret_entry_o.data        = dat_i;
    ret_entry_o.last        = beat_i.last;
  end

  always_comb begin
    case (beat_i.header.size)
      e_size_1: size_mask = wb_sel_t'(8'h01);
      e_size_2: size_mask = wb_sel_t'(8'h03);
      e_size_4: size_mask = wb_sel_t'(8'h0f);
      default:  size_mask = '1;
    endcase
  end

  assign burst_mask = beat_mask(beat_i.header.size);

  always_comb begin
    wb_req_o.adr = beat_i.addr[ADDR_W-1:OFF_W];
    wb_req_o.dat = beat_i.data;
    wb_req_o.sel = size_mask << beat_i.addr[OFF_W-1:0];
    wb_req_o.we  = (beat_i.header.msg_type == e_mem_uc_wr);
    wb_req_o.cti = beat_i.last ? e_wb_end_of_burst : e_wb_inc_addr_burst;
    // 2-beat bursts have no wrap code and go out linear
    case (burst_mask)
      beat_cnt_t'(3): wb_req_o.bte = e_wb_4_beat_wrap_burst;
      beat_cnt_t'(7): wb_req_o.bte = e_wb_8_beat_wrap_burst;
      default:        wb_req_o.bte = e_wb_linear_burst;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/fwd_stream_pump.sv ====
/* buffers two commands and splits each into bus beats
   wide reads are one message beat, wide writes one message beat per bus word */
`default_nettype none

`include "wb_bridge_params.svh"

module fwd_stream_pump (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  wb_bridge_pkg::fwd_msg_s fwd_msg_i,
  input  logic                   fwd_v_i,
  output logic                   fwd_ready_and_o,

  output wb_bridge_pkg::fsm_beat_s beat_o,
  output logic                   beat_v_o,
  input  logic                   beat_yumi_i
);

  import wb_bridge_pkg::*;

  localparam int OFF_W = `WB_OFFSET_WIDTH;
  localparam int CNT_W = `WB_BEAT_CNT_WIDTH;

  fwd_msg_s  head;
  logic      head_v;
  logic      head_yumi;
  logic      is_wr;
  beat_cnt_t cnt_q;
  beat_cnt_t mask;
  beat_cnt_t start_word;
  beat_cnt_t beat_word;

  two_entry_fifo #(
    .payload_t(fwd_msg_s)
  ) cmd_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (fwd_msg_i),
    .v_i    (fwd_v_i),
    .ready_o(fwd_ready_and_o),
    .data_o (head),
    .v_o    (head_v),
    .yumi_i (head_yumi)
  );

  assign is_wr      = (head.header.msg_type == e_mem_uc_wr);
  assign mask       = beat_mask(head.header.size);
  assign start_word = head.header.addr[OFF_W +: CNT_W];

  // wrap inside the size-aligned region, critical word first
  assign beat_word = (start_word & ~mask) | ((start_word + cnt_q) & mask);

  always_comb begin
    beat_o.header = head.header;
    beat_o.data   = head.data;
    beat_o.addr   = head.header.addr;
    beat_o.addr[OFF_W +: CNT_W] = beat_word;
    beat_o.last   = (cnt_q == mask);
  end

  assign beat_v_o = head_v;

  // a read message is replayed until its last beat goes out
  assign head_yumi = beat_yumi_i && (is_wr || beat_o.last);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (beat_yumi_i) begin
      cnt_q <= beat_o.last ? '0 : cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/two_entry_fifo.sv ====
/* two-slot valid/ready FIFO, yumi_i must only be raised while v_o is high
   ready_o stays low during reset and rises one cycle after release */
`default_nettype none

module two_entry_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,

  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  payload_t slot_q [2];
  logic wr_ptr_q, rd_ptr_q;
  logic full_q, ready_q;
  logic full_d;
  logic enq, deq;

  assign enq = v_i && ready_q;
  assign deq = yumi_i;

  // one entry held and one more arriving fills both slots
  always_comb begin
    full_d = full_q;
    if (enq && !deq) begin
      full_d = (wr_ptr_q != rd_ptr_q);
    end else if (deq && !enq) begin
      full_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (deq) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      full_q  <= full_d;
      ready_q <= !full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      slot_q[wr_ptr_q] <= data_i;
    end
  end

  assign ready_o = ready_q;
  assign data_o  = slot_q[rd_ptr_q];
  assign v_o     = (wr_ptr_q != rd_ptr_q) || full_q;

endmodule

`default_nettype wire

// ==== source/wb_bridge_pkg.sv ====
/* message, beat and Wishbone types for the bridge
   only uncached reads and writes are encoded */
`default_nettype none

`include "wb_bridge_params.svh"

package wb_bridge_pkg;

  typedef logic [`WB_PADDR_WIDTH-1:0] paddr_t;
  typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;
  typedef logic [`WB_SEL_WIDTH-1:0] wb_sel_t;
  typedef logic [`WB_ADR_WIDTH-1:0] wb_adr_t;
  typedef logic [`WB_BEAT_CNT_WIDTH-1:0] beat_cnt_t;

  typedef enum logic {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } msg_type_e;

  // encoded as log2 of the byte count
  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5,
    e_size_64 = 3'd6
  } msg_size_e;

  typedef struct packed {
    msg_type_e  msg_type;
    msg_size_e  size;
    paddr_t     addr;
    logic [7:0] tag;
  } mem_header_s;

  typedef struct packed {
    mem_header_s header;
    wb_data_t    data;
  } fwd_msg_s;

  typedef struct packed {
    mem_header_s header;
    wb_data_t    data;
    paddr_t      addr;
    logic        last;
  } fsm_beat_s;

  typedef enum logic [2:0] {
    e_wb_inc_addr_burst = 3'b010,
    e_wb_end_of_burst   = 3'b111
  } wb_cti_e;

  typedef enum logic [1:0] {
    e_wb_linear_burst       = 2'b00,
    e_wb_4_beat_wrap_burst  = 2'b01,
    e_wb_8_beat_wrap_burst  = 2'b10,
    e_wb_16_beat_wrap_burst = 2'b11
  } wb_bte_e;

  typedef struct packed {
    wb_adr_t  adr;
    wb_data_t dat;
    wb_sel_t  sel;
    logic     we;
    wb_cti_e  cti;
    wb_bte_e  bte;
  } wb_req_s;

  typedef struct packed {
    mem_header_s header;
    wb_data_t    data;
    logic        last;
  } rev_entry_s;

  // bus beats minus one, also the wrap mask on the word index
  function automatic beat_cnt_t beat_mask(msg_size_e size);
    case (size)
      e_size_16: beat_mask = beat_cnt_t'(1);
      e_size_32: beat_mask = beat_cnt_t'(3);
      e_size_64: beat_mask = beat_cnt_t'(`WB_BLOCK_WIDTH / `WB_DATA_WIDTH - 1);
      default:   beat_mask = '0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== source/wb_bridge_params.svh ====
/* bus and message widths for the bridge; only a 64-bit Wishbone bus is supported
   and WB_OFFSET_WIDTH must stay log2 of the byte lanes */
`ifndef WB_BRIDGE_PARAMS_SVH
`define WB_BRIDGE_PARAMS_SVH

// physical address and bus word
`define WB_PADDR_WIDTH 32
`define WB_DATA_WIDTH 64
`define WB_SEL_WIDTH 8
`define WB_OFFSET_WIDTH 3

// word address seen on adr
`define WB_ADR_WIDTH (`WB_PADDR_WIDTH - `WB_OFFSET_WIDTH)

// largest message is one 64-byte block
`define WB_BLOCK_WIDTH 512
`define WB_BEAT_CNT_WIDTH 3

`endif
